// ==== common/muldivOpPkg.sv ====
/*
 * Operation package for the multiply/divide unit
 * Holds the M-extension operation encoding and the issue command
 */

package muldivOpPkg;

  // Width of the tag that follows each request to its result
  localparam int TagW = 4;

  ////////////////////////////////////////////////////////////////////
  // Operation encoding
  ////////////////////////////////////////////////////////////////////

  // Same values as RISC-V funct3 for the M extension
  // Bit 2 set selects the divider
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } MulDivOp;

  ////////////////////////////////////////////////////////////////////
  // Issue command
  ////////////////////////////////////////////////////////////////////

  // Travels with the operands through either datapath
  typedef struct packed {
    MulDivOp          op;
    logic [TagW-1:0]  tag;
  } MulDivCmd;

endpackage

// ==== common/muldivResultPkg.sv ====
/*
 * Result package for the multiply/divide unit
 * Result source, divider FSM states and the result tag struct
 */

package muldivResultPkg;

  // Which peer drove the shared result bus
  typedef enum logic {
    SRC_MUL = 1'b0,
    SRC_DIV = 1'b1
  } ResultSrc;

  // Divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_FIX  = 2'd2,
    DIV_DONE = 2'd3
  } DivState;

  // Side information that goes out with every result
  typedef struct packed {
    logic [muldivOpPkg::TagW-1:0]  tag;
    ResultSrc                      src;
  } ResultInfo;

endpackage

// ==== mul/mul.sv ====
/*
 * Two-stage multiplier
 * Stage one forms four partial products with sign correction terms,
 * stage two adds them and keeps the low or high half of the product
 */

`timescale 1ns/10ps

module mul #(
  parameter int XLEN = 32
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    start,
  input  logic                    stall,
  input  logic                    flush,
  input  muldivOpPkg::MulDivCmd   cmd,
  input  logic [XLEN-1:0]         srcA,
  input  logic [XLEN-1:0]         srcB,
  output logic                    valid,
  output logic [XLEN-1:0]         res,
  output muldivOpPkg::MulDivCmd   resCmd
);

  // Operands split as A = A' +/- a*2^(XLEN-1), same for B
  // Product = A'B' + cross terms * 2^(XLEN-1) + ab * 2^(2XLEN-2)
  // Signs of the cross and top terms depend on the op

  logic [XLEN-1:0]        aLow;
  logic [XLEN-1:0]        bLow;
  logic [XLEN-2:0]        crossA;
  logic [XLEN-2:0]        crossB;
  logic                   topBit;
  logic                   isMulh;
  logic                   isMulhsu;
  logic [2*XLEN-1:0]      pp1;
  logic [2*XLEN-1:0]      pp2;
  logic [2*XLEN-1:0]      pp3;
  logic [2*XLEN-1:0]      pp4;

  // Stage one registers
  logic                   s1Valid;
  muldivOpPkg::MulDivCmd  s1Cmd;
  logic [2*XLEN-1:0]      s1Pp1;
  logic [2*XLEN-1:0]      s1Pp2;
  logic [2*XLEN-1:0]      s1Pp3;
  logic [2*XLEN-1:0]      s1Pp4;
  logic [2*XLEN-1:0]      product;

  //////////////////////////////////////////////////////////////////////
  // Stage one, partial products
  //////////////////////////////////////////////////////////////////////

  // Low bits with the sign bit cleared
  assign aLow = {1'b0, srcA[XLEN-2:0]};
  assign bLow = {1'b0, srcB[XLEN-2:0]};

  // Sign bit of one operand times low bits of the other
  assign crossA = {(XLEN-1){srcA[XLEN-1]}} & srcB[XLEN-2:0];
  assign crossB = {(XLEN-1){srcB[XLEN-1]}} & srcA[XLEN-2:0];
  assign topBit = srcA[XLEN-1] & srcB[XLEN-1];

  assign isMulh   = (cmd.op == muldivOpPkg::OP_MULH);
  assign isMulhsu = (cmd.op == muldivOpPkg::OP_MULHSU);

  // Unsigned core product
  assign pp1 = aLow * bLow;

  // Negative cross terms go in as one's complement
  // The missing +1 terms are folded into the pp4 constants
  assign pp2 = {2'b00, (isMulh | isMulhsu) ? ~crossA : crossA, {(XLEN-1){1'b0}}};
  assign pp3 = {2'b00, isMulh ? ~crossB : crossB, {(XLEN-1){1'b0}}};

  // Top term plus correction constants
  always_comb begin
    if (isMulh) begin
      pp4 = {1'b1, topBit, {(XLEN-3){1'b0}}, 1'b1, {XLEN{1'b0}}};
    end else if (isMulhsu) begin
      pp4 = {1'b1, ~topBit, {(XLEN-2){1'b0}}, 1'b1, {(XLEN-1){1'b0}}};
    end else begin
      // MUL and MULHU, fully unsigned sum
      pp4 = {1'b0, topBit, {(2*XLEN-2){1'b0}}};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage valids
  //////////////////////////////////////////////////////////////////////

  // Flush drops both stages and a same-cycle start
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
      valid   <= 1'b0;
    end else if (flush) begin
      s1Valid <= 1'b0;
      valid   <= 1'b0;
    end else if (!stall) begin
      s1Valid <= start;
      valid   <= s1Valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two, sum and half select
  //////////////////////////////////////////////////////////////////////

  // Multi-operand add, left for synthesis to map onto CSAs
  assign product = s1Pp1 + s1Pp2 + s1Pp3 + s1Pp4;

  // Payload pipeline, frozen on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      s1Pp1  <= pp1;
      s1Pp2  <= pp2;
      s1Pp3  <= pp3;
      s1Pp4  <= pp4;
      s1Cmd  <= cmd;
      resCmd <= s1Cmd;
      // Low half for MUL, high half for the MULH family
      res    <= (s1Cmd.op == muldivOpPkg::OP_MUL) ? product[XLEN-1:0]
                                                  : product[2*XLEN-1:XLEN];
    end
  end

endmodule

// ==== div/divIter.sv ====
/*
 * Iterative restoring divider
 * One quotient bit per cycle on magnitudes, then sign fix-up and the
 * RISC-V divide-by-zero and overflow results
 */

`timescale 1ns/10ps

module divIter #(
  parameter int XLEN = 32
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    start,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    grant,
  input  muldivOpPkg::MulDivCmd   cmd,
  input  logic [XLEN-1:0]         srcA,
  input  logic [XLEN-1:0]         srcB,
  output logic                    busy,
  output logic                    done,
  output logic [XLEN-1:0]         res,
  output muldivOpPkg::MulDivCmd   resCmd
);

  localparam int CntW = $clog2(XLEN);

  muldivResultPkg::DivState  state;
  logic [CntW-1:0]           stepCnt;

  // Decode of the incoming request
  logic                      signedOp;
  logic                      aNeg;
  logic                      bNeg;
  logic [XLEN-1:0]           absA;
  logic [XLEN-1:0]           absB;
  logic                      divZero;
  logic                      overflow;

  // Working registers
  logic [XLEN-1:0]           quoR;
  logic [XLEN-1:0]           remR;
  logic [XLEN-1:0]           divisorR;
  logic                      negQ;
  logic                      negR;
  logic                      zeroR;
  logic                      ovfR;

  // One shift-subtract step
  logic [XLEN:0]             shifted;
  logic [XLEN:0]             diff;

  // Fixed-up results
  logic [XLEN-1:0]           quoFix;
  logic [XLEN-1:0]           remFix;

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  // DIV and REM are signed, DIVU and REMU are not
  assign signedOp = ~cmd.op[0];
  assign aNeg     = signedOp & srcA[XLEN-1];
  assign bNeg     = signedOp & srcB[XLEN-1];
  assign absA     = aNeg ? -srcA : srcA;
  assign absB     = bNeg ? -srcB : srcB;
  assign divZero  = (srcB == '0);
  // Most negative value over -1
  assign overflow = signedOp & (srcA == {1'b1, {(XLEN-1){1'b0}}}) & (srcB == '1);

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Bring the next dividend bit into the partial remainder
  assign shifted = {remR, quoR[XLEN-1]};
  assign diff    = shifted - {1'b0, divisorR};

  // Quotient sign is the XOR of operand signs, remainder follows dividend
  always_comb begin
    quoFix = negQ ? -quoR : quoR;
    remFix = negR ? -remR : remR;
    if (zeroR) begin
      // x / 0 gives all ones, remainder falls out as the dividend
      quoFix = '1;
    end
    if (ovfR) begin
      quoFix = {1'b1, {(XLEN-1){1'b0}}};
      remFix = '0;
    end
  end

  // Payload registers, frozen on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      if (state == muldivResultPkg::DIV_IDLE && start) begin
        quoR     <= absA;
        remR     <= '0;
        divisorR <= absB;
        negQ     <= aNeg ^ bNeg;
        negR     <= aNeg;
        zeroR    <= divZero;
        ovfR     <= overflow;
        resCmd   <= cmd;
      end else if (state == muldivResultPkg::DIV_RUN) begin
        // Restore on borrow, else keep the difference and set the bit
        if (diff[XLEN]) begin
          remR <= shifted[XLEN-1:0];
          quoR <= {quoR[XLEN-2:0], 1'b0};
        end else begin
          remR <= diff[XLEN-1:0];
          quoR <= {quoR[XLEN-2:0], 1'b1};
        end
      end else if (state == muldivResultPkg::DIV_FIX) begin
        // op bit 1 picks remainder over quotient
        res <= resCmd.op[1] ? remFix : quoFix;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= muldivResultPkg::DIV_IDLE;
      stepCnt <= '0;
    end else if (flush) begin
      state   <= muldivResultPkg::DIV_IDLE;
      stepCnt <= '0;
    end else if (!stall) begin
      case (state)
        muldivResultPkg::DIV_IDLE: begin
          stepCnt <= '0;
          if (start) begin
            state <= muldivResultPkg::DIV_RUN;
          end
        end
        muldivResultPkg::DIV_RUN: begin
          // XLEN steps, then sign fix-up
          stepCnt <= stepCnt + 1'b1;
          if (stepCnt == CntW'(XLEN - 1)) begin
            state <= muldivResultPkg::DIV_FIX;
          end
        end
        muldivResultPkg::DIV_FIX: begin
          state <= muldivResultPkg::DIV_DONE;
        end
        muldivResultPkg::DIV_DONE: begin
          // Wait for the bus
          if (grant) begin
            state <= muldivResultPkg::DIV_IDLE;
          end
        end
        default: state <= muldivResultPkg::DIV_IDLE;
      endcase
    end
  end

  assign busy = (state != muldivResultPkg::DIV_IDLE);
  assign done = (state == muldivResultPkg::DIV_DONE);

endmodule

// ==== design/resultArbiter.sv ====
/*
 * Result bus arbiter
 * Fixed priority to the multiplier; the divider waits for a free cycle
 */

`timescale 1ns/10ps

module resultArbiter #(
  parameter int XLEN = 32
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         stall,
  input  logic                         mulValid,
  input  logic                         divDone,
  input  logic [XLEN-1:0]              mulRes,
  input  logic [XLEN-1:0]              divRes,
  input  muldivOpPkg::MulDivCmd        mulCmd,
  input  muldivOpPkg::MulDivCmd        divCmd,
  output logic                         divGrant,
  output logic                         resultValid,
  output logic [XLEN-1:0]              result,
  output muldivResultPkg::ResultInfo   resultInfo
);

  // Wide enough to count a few full divides of waiting
  localparam int CntW = $clog2(XLEN) + 2;

  // Cycles the divider lost to the multiplier since its last grant
  logic [CntW-1:0]  lostCycles;

  // A multiplier result cannot wait, so it always wins
  assign divGrant    = divDone & ~mulValid & ~stall;
  assign resultValid = (mulValid & ~stall) | divGrant;

  // Bus mux, result and tag from the same peer
  assign result         = mulValid ? mulRes : divRes;
  assign resultInfo.tag = mulValid ? mulCmd.tag : divCmd.tag;
  assign resultInfo.src = mulValid ? muldivResultPkg::SRC_MUL : muldivResultPkg::SRC_DIV;

  ////////////////////////////////////////////////////////////////////
  // Starvation counter
  ////////////////////////////////////////////////////////////////////

  // Saturates, cleared on grant
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lostCycles <= '0;
    end else if (!stall) begin
      if (divGrant || !divDone) begin
        lostCycles <= '0;
      end else if (lostCycles != '1) begin
        lostCycles <= lostCycles + 1'b1;
      end
    end
  end

endmodule

// ==== design/mulDivUnit.sv ====
/*
 * RISC-V multiply/divide unit
 * Routes issue to the multiplier or divider and merges their results
 */

`timescale 1ns/10ps

module mulDivUnit #(
  parameter int XLEN = 32
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         issue,
  input  logic                         stall,
  input  logic                         flush,
  input  muldivOpPkg::MulDivCmd        cmd,
  input  logic [XLEN-1:0]              srcA,
  input  logic [XLEN-1:0]              srcB,
  output logic                         resultValid,
  output logic [XLEN-1:0]              result,
  output muldivResultPkg::ResultInfo   resultInfo,
  output logic                         divBusy
);

  logic                   mulStart;
  logic                   divStart;

  // Multiplier to arbiter
  logic                   mulValid;
  logic [XLEN-1:0]        mulResult;
  muldivOpPkg::MulDivCmd  mulCmd;

  // Divider to arbiter
  logic                   divDone;
  logic                   divGrant;
  logic [XLEN-1:0]        divResult;
  muldivOpPkg::MulDivCmd  divCmd;

  // Issue steering, op bit 2 selects the divider
  assign mulStart = issue & ~stall & ~cmd.op[2];
  assign divStart = issue & ~stall & cmd.op[2];

  //////////////////////////////////////////////////////////////////////
  // Peers
  //////////////////////////////////////////////////////////////////////

  mul #(.XLEN(XLEN)) mul0 (
    .clk    (clk),
    .arstN  (arstN),
    .start  (mulStart),
    .stall  (stall),
    .flush  (flush),
    .cmd    (cmd),
    .srcA   (srcA),
    .srcB   (srcB),
    .valid  (mulValid),
    .res    (mulResult),
    .resCmd (mulCmd)
  );

  divIter #(.XLEN(XLEN)) div0 (
    .clk    (clk),
    .arstN  (arstN),
    .start  (divStart),
    .stall  (stall),
    .flush  (flush),
    .grant  (divGrant),
    .cmd    (cmd),
    .srcA   (srcA),
    .srcB   (srcB),
    .busy   (divBusy),
    .done   (divDone),
    .res    (divResult),
    .resCmd (divCmd)
  );

  // Shared result bus
  resultArbiter #(.XLEN(XLEN)) arbiter0 (
    .clk         (clk),
    .arstN       (arstN),
    .stall       (stall),
    .mulValid    (mulValid),
    .divDone     (divDone),
    .mulRes      (mulResult),
    .divRes      (divResult),
    .mulCmd      (mulCmd),
    .divCmd      (divCmd),
    .divGrant    (divGrant),
    .resultValid (resultValid),
    .result      (result),
    .resultInfo  (resultInfo)
  );

endmodule

// ==== tests/mulDivUnit_assertions.sv ====
/*
 * Protocol checks for the multiply/divide unit
 * Divider issue, stall, grant, run length and starvation
 */

`timescale 1ns/10ps

module mulDivUnitAssertions #(
  parameter int XLEN = 32
) (
  input logic                      clk,
  input logic                      arstN,
  input logic                      issue,
  input logic                      stall,
  input logic                      flush,
  input muldivOpPkg::MulDivCmd     cmd,
  input logic                      divBusy,
  input logic                      resultValid,
  input logic                      divGrant,
  input logic                      divDone,
  input muldivResultPkg::DivState  divState,
  input logic [$clog2(XLEN)+1:0]   lostCycles
);

  // Live cycles spent in DIV_RUN
  logic [$clog2(XLEN):0]  runSteps;

  int  issueFails = 0;
  int  stallFails = 0;
  int  grantFails = 0;
  int  runFails   = 0;
  int  waitFails  = 0;
  int  failCount;

  assign failCount = issueFails + stallFails + grantFails + runFails + waitFails;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      runSteps <= '0;
    end else if (divState != muldivResultPkg::DIV_RUN) begin
      runSteps <= '0;
    end else if (!stall) begin
      runSteps <= runSteps + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////

  divIssue: assert property (@(posedge clk) disable iff (!arstN)
    issue && cmd.op[2] && !stall |-> !divBusy)
    else begin
      issueFails++;
      $error("Divide issued while the divider is busy");
    end

  // Stall keeps the result bus quiet and freezes the divider FSM
  stallQuiet: assert property (@(posedge clk) disable iff (!arstN)
    stall |-> !resultValid ##1 ($stable(divState) || $past(flush)))
    else begin
      stallFails++;
      $error("Result valid or divider moving during stall");
    end

  // A grant takes a finished result and retires it
  grantDone: assert property (@(posedge clk) disable iff (!arstN)
    divGrant |-> divDone ##1 !divDone)
    else begin
      grantFails++;
      $error("Divider granted without a finished result");
    end

  // Last step moves on to the sign fix-up
  runLength: assert property (@(posedge clk) disable iff (!arstN)
    divState == muldivResultPkg::DIV_RUN && runSteps == XLEN - 1 && !stall && !flush
    |=> divState == muldivResultPkg::DIV_FIX)
    else begin
      runFails++;
      $error("Divider did not leave the run state after XLEN steps");
    end

  divStarve: assert property (@(posedge clk) disable iff (!arstN)
    divDone |-> lostCycles != '1)
    else begin
      waitFails++;
      $error("Divider starved by the multiplier");
    end

endmodule

bind mulDivUnit mulDivUnitAssertions #(.XLEN(XLEN)) assert0 (
  .clk         (clk),
  .arstN       (arstN),
  .issue       (issue),
  .stall       (stall),
  .flush       (flush),
  .cmd         (cmd),
  .divBusy     (divBusy),
  .resultValid (resultValid),
  .divGrant    (divGrant),
  .divDone     (divDone),
  .divState    (div0.state),
  .lostCycles  (arbiter0.lostCycles)
);

// ==== tests/mulDivTb.sv ====
/*
 * Testbench for the multiply/divide unit
 * File vectors, then seeded random traffic, each result matched by tag
 * against a RISC-V reference model
 */

`timescale 1ns/10ps

module mulDivTb;

  localparam int XLEN      = 32;
  localparam int FileVecs  = 24;
  localparam int RandVecs  = 40;
  localparam int Words     = 6;
  localparam int NumTags   = 1 << muldivOpPkg::TagW;
  localparam int MaxCycles = (FileVecs + RandVecs) * (XLEN + 8) + 200;

  logic                        clk;
  logic                        arstN;
  logic                        issue;
  logic                        stall;
  logic                        flush;
  muldivOpPkg::MulDivCmd       cmd;
  logic [XLEN-1:0]             srcA;
  logic [XLEN-1:0]             srcB;
  logic                        resultValid;
  logic [XLEN-1:0]             result;
  muldivResultPkg::ResultInfo  resultInfo;
  logic                        divBusy;

  // Six words per vector: op, srcA, srcB, tag, stall cycles, flush
  logic [XLEN-1:0]  stim [FileVecs*Words];

  // Scoreboard, one slot per tag
  logic                       pendValid [NumTags];
  logic [XLEN-1:0]            pendExp   [NumTags];
  muldivResultPkg::ResultSrc  pendSrc   [NumTags];
  int                         pendStart [NumTags];

  int  valueErrors = 0;
  int  protoErrors = 0;
  int  cycleCount  = 0;
  // Non-stalled cycles since reset
  int  liveCount   = 0;
  int  seed;
  int  nextTag;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  mulDivUnit #(.XLEN(XLEN)) dut0 (
    .clk         (clk),
    .arstN       (arstN),
    .issue       (issue),
    .stall       (stall),
    .flush       (flush),
    .cmd         (cmd),
    .srcA        (srcA),
    .srcB        (srcB),
    .resultValid (resultValid),
    .result      (result),
    .resultInfo  (resultInfo),
    .divBusy     (divBusy)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] refModel(input muldivOpPkg::MulDivOp op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0]       extA;
    logic [2*XLEN-1:0]       extB;
    logic [2*XLEN-1:0]       prod;
    logic signed [XLEN-1:0]  sa;
    logic signed [XLEN-1:0]  sb;
    logic signed [XLEN-1:0]  sq;
    logic signed [XLEN-1:0]  sr;
    logic                    ovf;
    logic [XLEN-1:0]         res;
    sa  = a;
    sb  = b;
    ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
    // Signed quotient and remainder where the plain division is defined
    sq  = '0;
    sr  = '0;
    if (b != '0 && !ovf) begin
      sq = sa / sb;
      sr = sa % sb;
    end
    // Signed operands widen with their sign, unsigned with zeros
    extA = {{XLEN{a[XLEN-1] & (op != muldivOpPkg::OP_MULHU)}}, a};
    extB = {{XLEN{b[XLEN-1] & (op == muldivOpPkg::OP_MULH)}}, b};
    prod = extA * extB;
    case (op)
      muldivOpPkg::OP_MUL:  res = prod[XLEN-1:0];
      muldivOpPkg::OP_DIV:  res = (b == '0) ? '1 : (ovf ? a : sq);
      muldivOpPkg::OP_DIVU: res = (b == '0) ? '1 : a / b;
      muldivOpPkg::OP_REM:  res = (b == '0) ? a : (ovf ? '0 : sr);
      muldivOpPkg::OP_REMU: res = (b == '0) ? a : a % b;
      // MULH, MULHSU and MULHU
      default:              res = prod[2*XLEN-1:XLEN];
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic checkResult(input string name, input logic [XLEN-1:0] expVal,
                             input logic [XLEN-1:0] gotVal);
    if (gotVal !== expVal) begin
      valueErrors++;
      $display("FAILED %s expected 0x%h got 0x%h at %0t", name, expVal, gotVal, $time);
    end
  endtask

  task automatic checkInfo(input string name, input muldivResultPkg::ResultInfo expVal,
                           input muldivResultPkg::ResultInfo gotVal);
    if (gotVal !== expVal) begin
      valueErrors++;
      $display("FAILED %s expected 0x%h got 0x%h at %0t", name, expVal, gotVal, $time);
    end
  endtask

  task automatic checkFlag(input string name, input logic expVal, input logic gotVal);
    if (gotVal !== expVal) begin
      valueErrors++;
      $display("FAILED %s expected 0x%h got 0x%h at %0t", name, expVal, gotVal, $time);
    end
  endtask

  function automatic int totalErrors();
    return valueErrors + protoErrors + dut0.assert0.failCount;
  endfunction

  function automatic logic anyPending();
    for (int t = 0; t < NumTags; t++) begin
      if (pendValid[t]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic reportMissing();
    for (int t = 0; t < NumTags; t++) begin
      if (pendValid[t]) begin
        protoErrors++;
        $display("Item with tag %0d never produced a result", t);
      end
    end
  endtask

  task automatic printCounts();
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             valueErrors, protoErrors, dut0.assert0.failCount);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle counters and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycleCount++;
    if (arstN && !stall) begin
      liveCount++;
    end
    if (cycleCount >= MaxCycles) begin
      $display("Timeout after %0d cycles, the run did not finish", cycleCount);
      reportMissing();
      printCounts();
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Outputs settle by mid-cycle, so results are taken on the falling edge
  always @(negedge clk) begin : monitor
    muldivResultPkg::ResultInfo    expInfo;
    logic [muldivOpPkg::TagW-1:0]  tag;
    if (arstN === 1'b1 && resultValid === 1'b1) begin
      tag = resultInfo.tag;
      if (stall) begin
        protoErrors++;
        $display("Result valid while stall is high at %0t", $time);
      end
      if (!pendValid[tag]) begin
        protoErrors++;
        $display("Result with tag %0d arrived but nothing with that tag is pending", tag);
      end else begin
        expInfo.tag = tag;
        expInfo.src = pendSrc[tag];
        checkResult("result", pendExp[tag], result);
        checkInfo("resultInfo", expInfo, resultInfo);
        // Multiply is two live cycles, divide at least XLEN+2
        if (pendSrc[tag] == muldivResultPkg::SRC_MUL && liveCount != pendStart[tag] + 2) begin
          protoErrors++;
          $display("Multiply with tag %0d took %0d live cycles instead of 2",
                   tag, liveCount - pendStart[tag]);
        end
        if (pendSrc[tag] == muldivResultPkg::SRC_DIV && liveCount < pendStart[tag] + XLEN + 2) begin
          protoErrors++;
          $display("Divide with tag %0d finished too early", tag);
        end
        pendValid[tag] = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drive tasks
  //////////////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic issueOp(input muldivOpPkg::MulDivOp op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b,
                         input logic [muldivOpPkg::TagW-1:0] tag,
                         input logic withFlush);
    // One divide at a time, and a tag only once its last result is back
    while (pendValid[tag] || (op[2] && divBusy)) begin
      nextCycle();
    end
    issue   = 1'b1;
    flush   = withFlush;
    cmd.op  = op;
    cmd.tag = tag;
    srcA    = a;
    srcB    = b;
    // Request issued with flush is dropped
    if (!withFlush) begin
      pendValid[tag] = 1'b1;
      pendExp[tag]   = refModel(op, a, b);
      pendSrc[tag]   = op[2] ? muldivResultPkg::SRC_DIV : muldivResultPkg::SRC_MUL;
      pendStart[tag] = liveCount;
    end
    nextCycle();
    issue = 1'b0;
    flush = 1'b0;
    if (withFlush) begin
      // Nothing in flight survives the flush edge
      for (int t = 0; t < NumTags; t++) begin
        pendValid[t] = 1'b0;
      end
      checkFlag("divBusy", 1'b0, divBusy);
    end
  endtask

  task automatic holdStall(input int cycles);
    stall = 1'b1;
    repeat (cycles) nextCycle();
    stall = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [XLEN-1:0]        rnd;
    muldivOpPkg::MulDivOp   op;
    arstN   = 1'b0;
    issue   = 1'b0;
    stall   = 1'b0;
    flush   = 1'b0;
    cmd     = '0;
    srcA    = '0;
    srcB    = '0;
    seed    = 82098;
    nextTag = 0;
    for (int t = 0; t < NumTags; t++) begin
      pendValid[t] = 1'b0;
    end
    $readmemh("tests/mulDivStim.txt", stim);
    repeat (16) @(posedge clk);
    #1;
    arstN = 1'b1;
    nextCycle();

    // Directed vectors
    for (int v = 0; v < FileVecs; v++) begin
      issueOp(muldivOpPkg::MulDivOp'(stim[v*Words][2:0]), stim[v*Words+1],
              stim[v*Words+2], stim[v*Words+3][muldivOpPkg::TagW-1:0], stim[v*Words+5][0]);
      if (stim[v*Words+4] != 0) begin
        holdStall(stim[v*Words+4]);
      end
    end

    // Random traffic, a divide then a multiply stream that runs past its end
    for (int k = 0; k < RandVecs; k++) begin
      a   = $random(seed);
      b   = $random(seed);
      rnd = $random(seed);
      if (k == 0 || k >= RandVecs - 4) begin
        op = muldivOpPkg::MulDivOp'({1'b1, rnd[1:0]});
      end else begin
        op = muldivOpPkg::MulDivOp'({1'b0, rnd[1:0]});
      end
      for (int t = 0; t < NumTags && pendValid[nextTag]; t++) begin
        nextTag = (nextTag + 1) % NumTags;
      end
      issueOp(op, a, b, nextTag[muldivOpPkg::TagW-1:0], 1'b0);
      nextTag = (nextTag + 1) % NumTags;
    end

    // Drain what is still in flight, then a few cycles for stray results
    while (anyPending()) begin
      nextCycle();
    end
    repeat (4) nextCycle();
    reportMissing();
    printCounts();
    if (totalErrors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tests/mulDivStim.txt ====
// op srcA srcB tag stall flush, all hex, op is funct3
// stall counts cycles held after issue, flush drops the vector and all work in flight
0 00000007 00000006 0 0 0
0 80000000 ffffffff 1 0 0
1 80000000 80000000 2 0 0
1 ffffffff ffffffff 3 0 0
2 ffffffff ffffffff 4 0 0
3 ffffffff ffffffff 5 0 0
2 7fffffff 80000000 6 3 0
1 12345678 9abcdef0 7 0 0
4 00000064 00000007 8 0 0
4 ffffff9c 00000007 9 0 0
6 ffffff9c 00000007 a 0 0
5 ffffff9c 00000007 b 0 0
7 ffffff9c 00000007 c 2 0
4 00000064 00000000 d 0 0
6 80000001 00000000 e 0 0
5 12345678 00000000 f 0 0
7 12345678 00000000 0 0 0
4 80000000 ffffffff 1 0 0
6 80000000 ffffffff 2 0 0
6 00000064 fffffff9 3 0 0
// A divide and a multiply in flight, then cancelled by a flush
4 7fffffff 00000003 4 0 0
3 deadbeef 00000010 5 0 0
0 00000003 00000005 6 0 1
4 fffffff9 00000002 7 0 0

// ==== filelist.f ====
common/muldivOpPkg.sv
common/muldivResultPkg.sv
mul/mul.sv
div/divIter.sv
design/resultArbiter.sv
design/mulDivUnit.sv
tests/mulDivUnit_assertions.sv
tests/mulDivTb.sv

// ==== Bender.yml ====
package:
  name: mul_div_unit

sources:
  # Shared packages
  - files:
      - common/muldivOpPkg.sv
      - common/muldivResultPkg.sv
  # Design
  - files:
      - mul/mul.sv
      - div/divIter.sv
      - design/resultArbiter.sv
      - design/mulDivUnit.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tests/mulDivUnit_assertions.sv
      - tests/mulDivTb.sv
